/* verilog/bus_types_pkg.sv */
package bus_types_pkg;

	// status encoding of the bus cycle, as seen on the processor status lines
	typedef enum logic [2:0] {
		io_read = 3'b001,
		io_write = 3'b010,
		memory_read = 3'b101,
		memory_write = 3'b110,
		passive = 3'b111
	} bus_cycle_type;

	// processor bus cycle states
	typedef enum logic [2:0] {
		idle = 3'd0,
		t1 = 3'd1,
		t2 = 3'd2,
		t3 = 3'd3,
		tw = 3'd4,
		t4 = 3'd5
	} sequencer_state;

endpackage

/* verilog/timing_pkg.sv */
package timing_pkg;

	// system clocks per processor clock
	// one third high and two thirds low
	localparam int default_clock_divide = 3;

	// width of the wait state counters and of the device wait request
	localparam int wait_count_width = 4;

endpackage

/* verilog/cpu_clock_divider.sv */
module cpu_clock_divider
	import timing_pkg::*;
#(
	parameter int clock_divide = default_clock_divide
) (
	input logic clock,
	input logic reset,
	output logic cpu_clock,
	output logic cpu_clock_rise,
	output logic cpu_clock_fall
);
	localparam int high_count = (clock_divide / 3 > 0) ? clock_divide / 3 : 1;
	localparam int count_width = $clog2(clock_divide);

	logic [count_width-1:0] count;
	logic [count_width-1:0] count_next;

	assign count_next = (count == count_width'(clock_divide - 1)) ? '0 : count + 1'b1;

	// strobes come out of flops next to the clock so they line up with its edges
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			count <= count_width'(clock_divide - 1);
			cpu_clock <= 1'b0;
			cpu_clock_rise <= 1'b0;
			cpu_clock_fall <= 1'b0;
		end else begin
			count <= count_next;
			cpu_clock <= count_next < count_width'(high_count);
			cpu_clock_rise <= count_next == '0;
			cpu_clock_fall <= count_next == count_width'(high_count);
		end
	end

	// high phase is never empty, so the two edges can't meet
	assert property (@(posedge clock) disable iff (reset)
		!(cpu_clock_rise && cpu_clock_fall));

endmodule

/* verilog/bus_cycle_sequencer.sv */
module bus_cycle_sequencer
	import bus_types_pkg::*;
	import timing_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic cpu_clock_rise,
	input logic cycle_request,
	input bus_cycle_type cycle_type,
	input logic processor_ready,
	output logic io_read_n,
	output logic io_write_n,
	output logic memory_read_n,
	output logic memory_write_n,
	output logic io_cycle_start,
	output logic cycle_done,
	output logic [wait_count_width-1:0] wait_count
);
	sequencer_state state;
	sequencer_state state_next;
	bus_cycle_type active_type;
	logic request_pending;
	logic command_active;
	logic io_cycle;

	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				if (request_pending)
					state_next = t1;
			end
			t1: state_next = t2;
			t2: state_next = t3;
			// ready is looked at once at the end of t3 and again in every tw
			t3: state_next = processor_ready ? t4 : tw;
			tw: begin
				if (processor_ready)
					state_next = t4;
			end
			t4: state_next = idle;
			default: state_next = idle;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= idle;
			active_type <= passive;
			request_pending <= 1'b0;
			wait_count <= '0;
			cycle_done <= 1'b0;
		end else begin
			cycle_done <= 1'b0;
			// requests outside idle are dropped
			if (cycle_request && state == idle && !request_pending) begin
				request_pending <= 1'b1;
				active_type <= cycle_type;
			end
			if (cpu_clock_rise) begin
				state <= state_next;
				if (state == idle && request_pending) begin
					request_pending <= 1'b0;
					wait_count <= '0;
				end
				// saturate instead of wrapping on a long DMA hold
				if (state_next == tw && wait_count != '1)
					wait_count <= wait_count + 1'b1;
				if (state == t4)
					cycle_done <= 1'b1;
			end
		end
	end

	// command is on from t2 up to the start of t4
	assign command_active = (state == t2) || (state == t3) || (state == tw);

	assign io_read_n = !(command_active && active_type == io_read);
	assign io_write_n = !(command_active && active_type == io_write);
	assign memory_read_n = !(command_active && active_type == memory_read);
	assign memory_write_n = !(command_active && active_type == memory_write);

	assign io_cycle = (active_type == io_read) || (active_type == io_write);

	// one system clock on the last edge of t1, so the card sees the command coming
	assign io_cycle_start = cpu_clock_rise && state == t1 && io_cycle;

	assert property (@(posedge clock) disable iff (reset)
		$onehot0({!io_read_n, !io_write_n, !memory_read_n, !memory_write_n}));

	assert property (@(posedge clock) disable iff (reset)
		state == idle |-> (io_read_n && io_write_n && memory_read_n && memory_write_n));

endmodule

/* verilog/ready.sv */
module ready (
	input logic clock,
	input logic cpu_clock,
	input logic reset,
	output logic processor_ready,
	output logic dma_ready,
	input logic dma_wait_n,
	input logic io_channel_ready,
	input logic io_read_n,
	input logic io_write_n,
	input logic memory_read_n,
	input logic dma0_acknowledge_n,
	input logic address_enable_n
);
	logic prev_cpu_clock;
	logic cpu_clock_posedge;
	logic cpu_clock_negedge;
	logic bus_state;
	logic prev_bus_state;
	logic ready_n_or_wait;
	logic ready_n_or_wait_qn;
	logic prev_ready_n_or_wait;
	logic processor_ready_ff_1;
	logic processor_ready_ff_2;

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			prev_cpu_clock <= 1'b0;
		else
			prev_cpu_clock <= cpu_clock;
	end

	assign cpu_clock_posedge = !prev_cpu_clock && cpu_clock;
	assign cpu_clock_negedge = prev_cpu_clock && !cpu_clock;

	// I/O command, or a memory read that isn't a DMA transfer
	assign bus_state = !io_read_n || !io_write_n
		|| (dma0_acknowledge_n && !memory_read_n && address_enable_n);

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			prev_bus_state <= 1'b1;
		else
			prev_bus_state <= bus_state;
	end

	// channel ready outranks a new bus state
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			ready_n_or_wait <= 1'b1;
			ready_n_or_wait_qn <= 1'b0;
		end else if (!io_channel_ready && prev_ready_n_or_wait) begin
			ready_n_or_wait <= 1'b1;
			ready_n_or_wait_qn <= 1'b1;
		end else if (!io_channel_ready && !prev_ready_n_or_wait) begin
			ready_n_or_wait <= 1'b1;
			ready_n_or_wait_qn <= 1'b0;
		end else if (io_channel_ready && prev_ready_n_or_wait) begin
			ready_n_or_wait <= 1'b0;
			ready_n_or_wait_qn <= 1'b1;
		end else if (!prev_bus_state && bus_state) begin
			ready_n_or_wait <= 1'b1;
			ready_n_or_wait_qn <= 1'b0;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			prev_ready_n_or_wait <= 1'b0;
		else if (cpu_clock_posedge)
			prev_ready_n_or_wait <= ready_n_or_wait;
	end

	assign dma_ready = !prev_ready_n_or_wait && ready_n_or_wait_qn;

	// first stage on the rising edge, second on the falling edge
	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			processor_ready_ff_1 <= 1'b0;
		else if (cpu_clock_posedge)
			processor_ready_ff_1 <= dma_wait_n && !ready_n_or_wait;
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			processor_ready_ff_2 <= 1'b0;
		else if (cpu_clock_negedge)
			processor_ready_ff_2 <= processor_ready_ff_1 && dma_wait_n && !ready_n_or_wait;
	end

	assign processor_ready = processor_ready_ff_2;

	// dma wait seen at a rising edge and still held at the next falling edge
	assert property (@(posedge clock) disable iff (reset)
		(!dma_wait_n && cpu_clock_posedge) ##1
		(!dma_wait_n throughout (cpu_clock_negedge [->1])) |=> !processor_ready);

endmodule

/* verilog/wait_state_timer.sv */
module wait_state_timer
	import timing_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic cpu_clock_rise,
	input logic io_cycle_start,
	input logic [wait_count_width-1:0] device_waits,
	output logic io_channel_ready
);
	logic [wait_count_width-1:0] remaining;

	// behaves like a slow card: ready drops as soon as the cycle is seen
	// and comes back on the rise after the count has run out
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			remaining <= '0;
			io_channel_ready <= 1'b1;
		end else if (io_cycle_start) begin
			remaining <= device_waits;
			// a fast card never pulls ready
			io_channel_ready <= device_waits == '0;
		end else if (cpu_clock_rise && !io_channel_ready) begin
			if (remaining == '0)
				io_channel_ready <= 1'b1;
			else
				remaining <= remaining - 1'b1;
		end
	end

endmodule

/* verilog/bus_controller_top.sv */
module bus_controller_top
	import bus_types_pkg::*;
	import timing_pkg::*;
#(
	parameter int clock_divide = default_clock_divide
) (
	input logic clock,
	input logic reset,
	input logic cycle_request,
	input bus_cycle_type cycle_type,
	input logic [wait_count_width-1:0] device_waits,
	input logic dma_wait_n,
	input logic dma0_acknowledge_n,
	input logic address_enable_n,
	output logic io_read_n,
	output logic io_write_n,
	output logic memory_read_n,
	output logic memory_write_n,
	output logic processor_ready,
	output logic dma_ready,
	output logic cycle_done,
	output logic [wait_count_width-1:0] wait_count
);
	logic cpu_clock;
	logic cpu_clock_rise;
	logic io_cycle_start;
	logic io_channel_ready;

	// falling strobe is only checked inside the divider
	cpu_clock_divider #(
		.clock_divide(clock_divide)
	) divider (
		.clock(clock),
		.reset(reset),
		.cpu_clock(cpu_clock),
		.cpu_clock_rise(cpu_clock_rise),
		.cpu_clock_fall()
	);

	bus_cycle_sequencer sequencer (
		.clock(clock),
		.reset(reset),
		.cpu_clock_rise(cpu_clock_rise),
		.cycle_request(cycle_request),
		.cycle_type(cycle_type),
		.processor_ready(processor_ready),
		.io_read_n(io_read_n),
		.io_write_n(io_write_n),
		.memory_read_n(memory_read_n),
		.memory_write_n(memory_write_n),
		.io_cycle_start(io_cycle_start),
		.cycle_done(cycle_done),
		.wait_count(wait_count)
	);

	ready ready_sync (
		.clock(clock),
		.cpu_clock(cpu_clock),
		.reset(reset),
		.processor_ready(processor_ready),
		.dma_ready(dma_ready),
		.dma_wait_n(dma_wait_n),
		.io_channel_ready(io_channel_ready),
		.io_read_n(io_read_n),
		.io_write_n(io_write_n),
		.memory_read_n(memory_read_n),
		.dma0_acknowledge_n(dma0_acknowledge_n),
		.address_enable_n(address_enable_n)
	);

	wait_state_timer timer (
		.clock(clock),
		.reset(reset),
		.cpu_clock_rise(cpu_clock_rise),
		.io_cycle_start(io_cycle_start),
		.device_waits(device_waits),
		.io_channel_ready(io_channel_ready)
	);

endmodule

/* test/bus_controller_tb.sv */
module bus_controller_tb
	import bus_types_pkg::*;
	import timing_pkg::*;
();
	localparam int cycle_limit = 300;
	localparam int idle_gap = 6;
	localparam int clocks_per_test = 400;

	logic clock;
	logic reset;
	logic cycle_request;
	bus_cycle_type cycle_type;
	logic [wait_count_width-1:0] device_waits;
	logic dma_wait_n;
	logic dma0_acknowledge_n;
	logic address_enable_n;
	logic io_read_n;
	logic io_write_n;
	logic memory_read_n;
	logic memory_write_n;
	logic processor_ready;
	logic dma_ready;
	logic cycle_done;
	logic [wait_count_width-1:0] wait_count;

	// one entry per line of the test file
	logic [2:0] test_type [$];
	logic [wait_count_width-1:0] test_device_waits [$];
	logic test_dma0_acknowledge_n [$];
	logic test_address_enable_n [$];
	int test_dma_hold [$];
	logic [wait_count_width-1:0] test_waits [$];
	logic [3:0] test_strobe_mask [$];

	int errors = 0;
	int checks_run = 0;
	int watchdog_clocks = 0;
	logic tests_loaded = 1'b0;

	bus_controller_top #(
		.clock_divide(default_clock_divide)
	) DUT (
		.clock(clock),
		.reset(reset),
		.cycle_request(cycle_request),
		.cycle_type(cycle_type),
		.device_waits(device_waits),
		.dma_wait_n(dma_wait_n),
		.dma0_acknowledge_n(dma0_acknowledge_n),
		.address_enable_n(address_enable_n),
		.io_read_n(io_read_n),
		.io_write_n(io_write_n),
		.memory_read_n(memory_read_n),
		.memory_write_n(memory_write_n),
		.processor_ready(processor_ready),
		.dma_ready(dma_ready),
		.cycle_done(cycle_done),
		.wait_count(wait_count)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic check_value(input string signal_name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks_run++;
		if (actual !== expected) begin
			errors++;
			$display("ERR %s expected %0h actual %0h", signal_name, expected, actual);
		end
	endtask

	task automatic load_tests();
		int fd;
		int fields;
		logic [8*120-1:0] line;
		logic [31:0] kind;
		logic [31:0] waits;
		logic [31:0] ack_n;
		logic [31:0] aen_n;
		int hold;
		logic [31:0] expected_waits;
		logic [31:0] mask;
		fd = $fopen("test/bus_controller_tests.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open test/bus_controller_tests.txt");
		end else begin
			// comment and blank lines don't scan all seven fields
			while ($fgets(line, fd) != 0) begin
				fields = $sscanf(line, "%h %h %h %h %d %h %h", kind, waits, ack_n, aen_n,
					hold, expected_waits, mask);
				if (fields == 7) begin
					test_type.push_back(kind[2:0]);
					test_device_waits.push_back(waits[wait_count_width-1:0]);
					test_dma0_acknowledge_n.push_back(ack_n[0]);
					test_address_enable_n.push_back(aen_n[0]);
					test_dma_hold.push_back(hold);
					test_waits.push_back(expected_waits[wait_count_width-1:0]);
					test_strobe_mask.push_back(mask[3:0]);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_idle(input int clocks);
		repeat (clocks) begin
			@(negedge clock);
			check_value("command strobes", 4'hf,
				{io_read_n, io_write_n, memory_read_n, memory_write_n});
			check_value("cycle_done", 1'b0, cycle_done);
		end
	endtask

	task automatic run_cycle(input int index);
		int clocks;
		int hold;
		logic done_seen;
		logic dma_ready_low;
		logic [3:0] strobes_low;
		logic [3:0] seen_low;
		hold = test_dma_hold[index];
		done_seen = 1'b0;
		dma_ready_low = 1'b0;
		seen_low = 4'h0;
		clocks = 0;
		@(negedge clock);
		cycle_type = bus_cycle_type'(test_type[index]);
		device_waits = test_device_waits[index];
		dma0_acknowledge_n = test_dma0_acknowledge_n[index];
		address_enable_n = test_address_enable_n[index];
		dma_wait_n = (hold == 0);
		cycle_request = 1'b1;
		while (!done_seen && clocks < cycle_limit) begin
			@(negedge clock);
			cycle_request = 1'b0;
			clocks++;
			strobes_low = ~{io_read_n, io_write_n, memory_read_n, memory_write_n};
			seen_low = seen_low | strobes_low;
			if (!dma_ready)
				dma_ready_low = 1'b1;
			if (!$onehot0(strobes_low)) begin
				errors++;
				$display("test %0d: more than one command strobe low at once", index);
			end
			if (cycle_done) begin
				done_seen = 1'b1;
				if (!dma_wait_n) begin
					errors++;
					$display("test %0d: cycle_done pulsed while DMA wait was still held", index);
				end
			end
			if (hold != 0 && clocks == hold)
				dma_wait_n = 1'b1;
		end
		dma_wait_n = 1'b1;
		if (!done_seen) begin
			errors++;
			$display("test %0d: no cycle_done within %0d clocks", index, cycle_limit);
		end else begin
			// with a hold the file gives the count of the same cycle without one
			if (hold == 0) begin
				check_value("wait_count", test_waits[index], wait_count);
			end else begin
				checks_run++;
				if (wait_count <= test_waits[index]) begin
					errors++;
					$display("ERR wait_count not above %0h with DMA wait held, actual %0h",
						test_waits[index], wait_count);
				end
			end
			check_value("command strobes low", test_strobe_mask[index], seen_low);
			// the not-ready that makes the wait state also takes DMA ready away
			check_value("dma_ready low during cycle", test_waits[index] != 0, dma_ready_low);
			check_value("dma_ready", 1'b1, dma_ready);
		end
	endtask

	initial begin : watchdog
		sequencer_state stuck_state;
		wait (tests_loaded);
		repeat (watchdog_clocks) @(posedge clock);
		stuck_state = DUT.sequencer.state;
		$display("timeout: run did not finish within %0d clocks, sequencer stuck in %s",
			watchdog_clocks, stuck_state.name());
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin : main_flow
		int index;
		reset = 1'b1;
		cycle_request = 1'b0;
		cycle_type = passive;
		device_waits = '0;
		dma_wait_n = 1'b1;
		dma0_acknowledge_n = 1'b1;
		address_enable_n = 1'b1;
		load_tests();
		watchdog_clocks = (test_type.size() + 1) * clocks_per_test;
		tests_loaded = 1'b1;

		repeat (2) @(negedge clock);
		check_value("command strobes", 4'hf,
			{io_read_n, io_write_n, memory_read_n, memory_write_n});
		check_value("cycle_done", 1'b0, cycle_done);
		check_value("processor_ready", 1'b0, processor_ready);
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		if (test_type.size() == 0) begin
			errors++;
			$display("no tests found in test/bus_controller_tests.txt");
		end
		check_idle(idle_gap);
		for (index = 0; index < test_type.size(); index++) begin
			run_cycle(index);
			check_idle(idle_gap);
		end

		$display("%0d tests, %0d checks, %0d errors", test_type.size(), checks_run, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* sources.f */
verilog/bus_types_pkg.sv
verilog/timing_pkg.sv
verilog/cpu_clock_divider.sv
verilog/bus_cycle_sequencer.sv
verilog/ready.sv
verilog/wait_state_timer.sv
verilog/bus_controller_top.sv
test/bus_controller_tb.sv

/* test/bus_controller_tests.txt */
// type(hex) device_waits dma0_ack_n address_enable_n dma_hold(clocks) waits(hex) strobe_mask(hex)
// waits is exact with no hold, with a hold the count must end up above it
// strobe mask bits are io_read, io_write, memory_read, memory_write from high to low
6 0 1 1 0 0 1
6 3 1 1 0 0 1
1 0 1 1 0 1 8
1 1 1 1 0 2 8
1 2 1 1 0 3 8
1 3 1 1 0 4 8
1 4 1 1 0 5 8
1 5 1 1 0 6 8
2 0 1 1 0 1 4
2 1 1 1 0 2 4
2 2 1 1 0 3 4
2 3 1 1 0 4 4
2 4 1 1 0 5 4
2 5 1 1 0 6 4
5 0 1 1 0 1 2
5 2 1 1 0 1 2
5 0 0 1 0 0 2
5 0 1 0 0 0 2
6 0 1 1 24 0 1
5 0 1 1 24 1 2
1 2 1 1 36 3 8
2 0 1 1 30 1 4
6 0 1 1 0 0 1
